// File: hdl/activationBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module activationBuffer #(
	parameter int NumInputs = neuralPkg::DefaultInputs
) (
	input wire logic clk,
	input wire logic reset,
	input wire neuralPkg::actT actIn,
	input wire logic actStrobe,
	input wire logic clear,
	output neuralPkg::actT acts [NumInputs],
	output logic full
);

	localparam int CountWidth = $clog2(NumInputs + 1);

	logic [CountWidth-1:0] fillCount;
	logic accept;

	assign full = fillCount == CountWidth'(NumInputs);
	assign accept = actStrobe && !full; // Strobes are dropped until the controller clears

	always_ff @(posedge clk)
	begin
		if (reset)
			fillCount <= '0;
		else if (clear)
			fillCount <= '0; // Data stays put, only the count restarts
		else if (accept)
			fillCount <= fillCount + 1'b1;
	end

	// Newest value enters at the top, so the first strobe lands at index 0
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			for (int i = 0; i < NumInputs - 1; i++)
				acts[i] <= acts[i + 1];
			acts[NumInputs - 1] <= actIn;
		end
	end

	assert property (@(posedge clk) disable iff (reset) actStrobe |-> !full)
		else $error("activationBuffer: strobe while the vector is full");

	assert property (@(posedge clk) disable iff (reset) fillCount <= CountWidth'(NumInputs))
		else $error("activationBuffer: fill count past the vector length");

endmodule

`default_nettype wire

// File: hdl/layerControl.sv
`timescale 1ns/1ps
`default_nettype none

module layerControl #(
	parameter int NumNeurons = neuralPkg::DefaultNeurons
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic full,
	output logic clear,
	output neuralPkg::neuronIdxT index,
	output neuralPkg::neuronIdxT resultIndex,
	output logic resultStrobe,
	output logic done,
	output logic busy
);
	import neuralPkg::*;

	localparam int PipeDepth = 4; // Weight table plus three neuron stages
	localparam neuronIdxT LastIndex = neuronIdxT'(NumNeurons - 1);

	layerStateT state;
	layerStateT stateNext;
	issueT issueNow;
	issueT issuePipe [PipeDepth];
	logic lastIssue;

	assign lastIssue = index == LastIndex;
	assign issueNow = '{valid: state == Issue, index: index};
	assign clear = state == Issue && index == '0; // First issue releases the buffer count

	always_comb
	begin
		stateNext = state;
		case (state)
			Idle: stateNext = Load;
			Load:
				if (full)
					stateNext = Issue;
			Issue:
				if (lastIssue)
					stateNext = Drain;
			Drain:
				if (done)
					stateNext = Load;
			default: stateNext = Idle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= Idle;
			index <= '0;
		end
		else
		begin
			state <= stateNext;
			if (state == Issue)
				index <= lastIssue ? '0 : index + 1'b1; // One neuron per cycle
		end
	end

	// Each issue record walks alongside its neuron through ROM and datapath
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < PipeDepth; i++)
				issuePipe[i] <= '0;
		end
		else
		begin
			issuePipe[0] <= issueNow;
			for (int i = 1; i < PipeDepth; i++)
				issuePipe[i] <= issuePipe[i - 1];
		end
	end

	assign resultStrobe = issuePipe[PipeDepth - 1].valid;
	assign resultIndex = issuePipe[PipeDepth - 1].index;
	assign done = resultStrobe && resultIndex == LastIndex;
	assign busy = state == Issue || state == Drain;

	assert property (@(posedge clk) disable iff (reset)
		resultStrobe |-> state inside {Issue, Drain})
		else $error("layerControl: result strobe outside a computation");

	assert property (@(posedge clk) disable iff (reset) done |=> !busy)
		else $error("layerControl: busy still high after done");

endmodule

`default_nettype wire

// File: hdl/neuralLayer.sv
`timescale 1ns/1ps
`default_nettype none

module neuralLayer #(
	parameter int NumInputs = neuralPkg::DefaultInputs,
	parameter int NumNeurons = neuralPkg::DefaultNeurons
) (
	input wire logic clk,
	input wire logic reset,
	input wire neuralPkg::actT actIn,
	input wire logic actStrobe,
	output neuralPkg::resultT result,
	output logic resultStrobe,
	output logic done,
	output logic busy
);
	import neuralPkg::*;

	actT acts [NumInputs];
	weightT weights [NumInputs];
	weightT bias;
	logic full;
	logic clear;
	neuronIdxT index;
	neuronIdxT resultIndex;
	actT activation;

	activationBuffer #(.NumInputs(NumInputs)) buffer (
		.clk(clk),
		.reset(reset),
		.actIn(actIn),
		.actStrobe(actStrobe),
		.clear(clear),
		.acts(acts),
		.full(full)
	);

	layerControl #(.NumNeurons(NumNeurons)) control (
		.clk(clk),
		.reset(reset),
		.full(full),
		.clear(clear),
		.index(index),
		.resultIndex(resultIndex),
		.resultStrobe(resultStrobe),
		.done(done),
		.busy(busy)
	);

	weightRom #(.NumInputs(NumInputs), .NumNeurons(NumNeurons)) rom (
		.clk(clk),
		.index(index),
		.weights(weights),
		.bias(bias)
	);

	neuronNode #(.NumInputs(NumInputs)) neuron (
		.clk(clk),
		.reset(reset),
		.acts(acts),
		.weights(weights),
		.bias(bias),
		.activation(activation)
	);

	assign result = '{index: resultIndex, value: activation}; // Delay line keeps both aligned

endmodule

`default_nettype wire

// File: hdl/neuralPkg.sv
`default_nettype none

package neuralPkg;

	parameter int DefaultInputs = 30; // Activations per vector
	parameter int DefaultNeurons = 10;

	typedef logic signed [7:0] actT;
	typedef logic signed [7:0] weightT; // Weights and biases share the int8 format
	typedef logic [3:0] neuronIdxT; // Up to 16 neurons

	// One slot of the controller's in-flight delay line
	typedef struct packed {
		logic valid;
		neuronIdxT index;
	} issueT;

	typedef struct packed {
		neuronIdxT index;
		actT value;
	} resultT;

	typedef enum logic [1:0] {
		Idle,
		Load,
		Issue,
		Drain
	} layerStateT;

endpackage

`default_nettype wire

// File: hdl/neuronNode.sv
`timescale 1ns/1ps
`default_nettype none

module neuronNode #(
	parameter int NumInputs = neuralPkg::DefaultInputs
) (
	input wire logic clk,
	input wire logic reset,
	input wire neuralPkg::actT acts [NumInputs],
	input wire neuralPkg::weightT weights [NumInputs],
	input wire neuralPkg::weightT bias,
	output neuralPkg::actT activation
);
	import neuralPkg::*;

	actT actsQ [NumInputs]; // Stage 1
	weightT weightsQ [NumInputs];
	weightT biasQ;
	actT sumNext;
	actT sumQ; // Stage 2

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < NumInputs; i++)
			begin
				actsQ[i] <= '0;
				weightsQ[i] <= '0;
			end
			biasQ <= '0;
		end
		else
		begin
			actsQ <= acts;
			weightsQ <= weights;
			biasQ <= bias;
		end
	end

	// Everything is 8 bits wide, so each product and the running sum wrap
	always_comb
	begin
		sumNext = biasQ;
		for (int i = 0; i < NumInputs; i++)
			sumNext = sumNext + actsQ[i] * weightsQ[i]; // Low byte of the product only
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumQ <= '0;
			activation <= '0;
		end
		else
		begin
			sumQ <= sumNext;
			activation <= sumQ[7] ? '0 : sumQ; // ReLU on the wrapped byte
		end
	end

endmodule

`default_nettype wire

// File: hdl/weightRom.sv
`timescale 1ns/1ps
`default_nettype none

module weightRom #(
	parameter int NumInputs = neuralPkg::DefaultInputs,
	parameter int NumNeurons = neuralPkg::DefaultNeurons
) (
	input wire logic clk,
	input wire neuralPkg::neuronIdxT index,
	output neuralPkg::weightT weights [NumInputs],
	output neuralPkg::weightT bias
);

	`include "layerWeights.svh"

	// The layer may use fewer rows or columns than the table holds, never more
	if (NumNeurons > LayerRows || NumInputs > LayerCols)
	begin : gTableCheck
		$error("weightRom: layer is larger than the weight table");
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < NumInputs; i++)
			weights[i] <= LayerWeights[index][i]; // Row lands one cycle after the index
		bias <= LayerBias[index];
	end

	// Index comes from the controller and must stay inside the layer
	assert property (@(posedge clk) !$isunknown(index) |-> index < NumNeurons)
		else $error("weightRom: neuron index %0d out of range", index);

endmodule

`default_nettype wire

// File: include/layerWeights.svh
// Rows are indexed by neuron, columns by input position in the activation vector
localparam int LayerRows = 10;
localparam int LayerCols = 30;

localparam neuralPkg::weightT LayerWeights [LayerRows][LayerCols] = '{
	'{8'shd2, 8'sh04, 8'sh60, 8'sha0, 8'shee, 8'sh3e, 8'sh05, 8'shd4, 8'sh0e, 8'she3,
		8'she4, 8'shf6, 8'sh21, 8'shdf, 8'sh20, 8'shd5, 8'sh02, 8'sh30, 8'shef, 8'shfc,
		8'sh11, 8'sh4e, 8'shfb, 8'sh23, 8'shcd, 8'she1, 8'shf7, 8'shfb, 8'sh4c, 8'sh13},
	'{8'sh1c, 8'shf3, 8'sh47, 8'sh0a, 8'shc8, 8'sh29, 8'she6, 8'sh52, 8'sh11, 8'shfd,
		8'sh3b, 8'sh9e, 8'sh07, 8'sh64, 8'shd9, 8'sh2a, 8'shf0, 8'sh15, 8'shb7, 8'sh48,
		8'sh0c, 8'she9, 8'sh33, 8'sh71, 8'sha6, 8'sh1f, 8'shd0, 8'sh5c, 8'sh08, 8'shec},
	'{8'sh6a, 8'sh02, 8'shdb, 8'sh37, 8'sh19, 8'shc1, 8'sh4f, 8'shfa, 8'sh23, 8'sh8c,
		8'sh10, 8'she7, 8'sh55, 8'sh0b, 8'shcc, 8'sh3d, 8'shf8, 8'sh26, 8'sh9a, 8'sh41,
		8'sh05, 8'shbe, 8'sh2f, 8'sh68, 8'shf1, 8'sh0d, 8'sh77, 8'shc4, 8'sh1a, 8'she2},
	'{8'shf4, 8'sh3a, 8'sh81, 8'sh16, 8'sh5d, 8'sh0f, 8'she0, 8'sh2c, 8'shb3, 8'sh49,
		8'shfe, 8'sh13, 8'sh6f, 8'shd7, 8'sh21, 8'sh8a, 8'sh39, 8'sh0e, 8'shc6, 8'sh5a,
		8'sheb, 8'sh17, 8'sh44, 8'sh93, 8'sh09, 8'shd3, 8'sh60, 8'sh2b, 8'shf7, 8'sh35},
	'{8'sh0b, 8'sh9c, 8'sh27, 8'she5, 8'sh72, 8'sh18, 8'shcf, 8'sh43, 8'sh06, 8'shb8,
		8'sh5e, 8'sh2d, 8'shf2, 8'sh14, 8'sh86, 8'sh3f, 8'shda, 8'sh61, 8'sh01, 8'shc9,
		8'sh38, 8'sh7a, 8'she8, 8'sh12, 8'sh4d, 8'shad, 8'sh25, 8'shf9, 8'sh69, 8'sh0c},
	'{8'shc3, 8'sh50, 8'sh1e, 8'shf6, 8'sh08, 8'sh9b, 8'sh34, 8'she1, 8'sh7c, 8'sh2e,
		8'shd5, 8'sh0a, 8'sh46, 8'shbb, 8'sh63, 8'sh19, 8'shf3, 8'sh28, 8'sh95, 8'sh0d,
		8'sh4a, 8'she6, 8'sh1b, 8'sh70, 8'shc0, 8'sh36, 8'shfb, 8'sh5f, 8'sh03, 8'sha9},
	'{8'sh2a, 8'she9, 8'sh5b, 8'sh04, 8'shb1, 8'sh66, 8'sh0f, 8'shd8, 8'sh31, 8'sh7f,
		8'shce, 8'sh12, 8'sh48, 8'shf5, 8'sh8e, 8'sh22, 8'sh07, 8'sh6c, 8'shdd, 8'sh39,
		8'sha4, 8'sh1d, 8'sh57, 8'shef, 8'sh10, 8'sh84, 8'sh3c, 8'shcb, 8'sh62, 8'sh15},
	'{8'sh47, 8'sh0e, 8'shcd, 8'sh73, 8'sh1a, 8'shea, 8'sh2f, 8'sh99, 8'sh54, 8'sh06,
		8'shf1, 8'sh3b, 8'shc2, 8'sh68, 8'sh0c, 8'shb6, 8'sh45, 8'shfc, 8'sh27, 8'sh8d,
		8'sh13, 8'sh5c, 8'she3, 8'sh36, 8'sha1, 8'sh79, 8'sh0b, 8'shd6, 8'sh2c, 8'sh4e},
	'{8'she7, 8'sh24, 8'sh03, 8'shbd, 8'sh58, 8'shf9, 8'sh11, 8'sh6d, 8'shc5, 8'sh32,
		8'sh80, 8'sh1f, 8'sh5a, 8'she2, 8'sh09, 8'sh74, 8'shac, 8'sh3e, 8'sh17, 8'shd1,
		8'sh65, 8'sh0a, 8'sh9f, 8'sh2b, 8'shf0, 8'sh43, 8'shc8, 8'sh1c, 8'sh56, 8'sh8b},
	'{8'sh10, 8'shc7, 8'sh6e, 8'sh29, 8'shf4, 8'sh05, 8'sh97, 8'sh3a, 8'shdc, 8'sh51,
		8'sh0d, 8'sh82, 8'sh37, 8'shea, 8'sh1e, 8'shc3, 8'sh6b, 8'sh04, 8'shb9, 8'sh2d,
		8'sh75, 8'shfa, 8'sh4c, 8'sh18, 8'she5, 8'sh02, 8'sh8f, 8'sh33, 8'shd4, 8'sh67}
};

// One bias per neuron, added before the ReLU
localparam neuralPkg::weightT LayerBias [LayerRows] = '{
	8'shf5, 8'sh0c, 8'she8, 8'sh21, 8'sh07, 8'shd6, 8'sh3a, 8'shfe, 8'sh14, 8'shc9
};

// File: neuralLayer.f
+incdir+include
hdl/neuralPkg.sv
hdl/activationBuffer.sv
hdl/weightRom.sv
hdl/neuronNode.sv
hdl/layerControl.sv
hdl/neuralLayer.sv
verification/clockGen.sv
verification/neuralLayerTb.sv

// File: verification/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
	parameter real Period = 4.0,
	parameter int ResetCycles = 3
) (
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #(Period / 2.0) clk = ~clk;
	end

	initial
	begin
		reset = 1'b1;
		repeat (ResetCycles) @(posedge clk);
		reset <= 1'b0; // Released on a rising edge like the other inputs
	end

endmodule

`default_nettype wire

// File: verification/neuralLayerTb.sv
`timescale 1ns/1ps
`default_nettype none

module neuralLayerTb;
	import neuralPkg::*;

	`include "layerWeights.svh"

	localparam int NumInputs = DefaultInputs;
	localparam int NumNeurons = DefaultNeurons;
	localparam neuronIdxT LastIndex = neuronIdxT'(NumNeurons - 1);
	localparam int DirectedTest = 0;
	localparam int RandomTest = 1;
	localparam int GappedTest = 2;
	localparam int BackToBackTest = 3;
	localparam int NumDirected = 4;
	localparam int NumRandom = 5;
	localparam int NumGapped = 4;
	localparam int NumBackToBack = 5;
	localparam int NumVectors = NumDirected + NumRandom + NumGapped + NumBackToBack;
	localparam int TimeoutCycles = NumVectors * (NumInputs + NumNeurons + 10);

	logic clk;
	logic reset;
	actT actIn;
	logic actStrobe;
	resultT result;
	logic resultStrobe;
	logic done;
	logic busy;

	actT stimVec [NumInputs];
	resultT expectQ [$];
	int testQ [$]; // Test of each expected record, for error lines
	resultT expectHead;
	int headTest;
	logic expectEmpty;
	int vectorsSent = 0;
	int vectorsDone = 0;
	int strobeCount = 0;
	logic vectorPending;
	int valueErrors = 0;
	int protocolErrors = 0;
	int clampHits = 0;
	int wrapHits = 0;

	assign vectorPending = vectorsSent != vectorsDone;

	clockGen clocks (
		.clk(clk),
		.reset(reset)
	);

	neuralLayer #(.NumInputs(NumInputs), .NumNeurons(NumNeurons)) DUT (
		.clk(clk),
		.reset(reset),
		.actIn(actIn),
		.actStrobe(actStrobe),
		.result(result),
		.resultStrobe(resultStrobe),
		.done(done),
		.busy(busy)
	);

	function automatic string testLabel(input int testId);
		case (testId)
			DirectedTest: return "reluWrap";
			RandomTest: return "randomValues";
			GappedTest: return "gappedStrobes";
			default: return "backToBack";
		endcase
	endfunction

	// Low byte of every product, summed with the bias in 8 bits
	function automatic logic [7:0] wrappedSum(input int neuron);
		logic [7:0] acc;
		logic signed [15:0] product;
		acc = LayerBias[neuron];
		for (int i = 0; i < NumInputs; i++)
		begin
			product = stimVec[i] * LayerWeights[neuron][i];
			acc = acc + product[7:0];
		end
		return acc;
	endfunction

	function automatic int fullSum(input int neuron);
		int sum;
		sum = LayerBias[neuron];
		for (int i = 0; i < NumInputs; i++)
			sum += int'(stimVec[i]) * int'(LayerWeights[neuron][i]);
		return sum;
	endfunction

	function automatic void refreshHead();
		expectEmpty = expectQ.size() == 0;
		expectHead = expectEmpty ? '0 : expectQ[0];
		headTest = expectEmpty ? -1 : testQ[0];
	endfunction

	function automatic void pushExpected(input int testId);
		logic [7:0] sum;
		resultT rec;
		for (int n = 0; n < NumNeurons; n++)
		begin
			sum = wrappedSum(n);
			rec.index = neuronIdxT'(n);
			rec.value = sum[7] ? '0 : actT'(sum); // Negative byte clamps to zero
			expectQ.push_back(rec);
			testQ.push_back(testId);
			if (testId == DirectedTest && sum[7])
				clampHits++;
			else if (testId == DirectedTest && fullSum(n) > 127)
				wrapHits++;
		end
		refreshHead();
	endfunction

	function automatic void randomVector();
		for (int i = 0; i < NumInputs; i++)
			stimVec[i] = actT'($urandom);
	endfunction

	// Extreme values so the sums wrap with either sign
	function automatic void patternVector(input int pattern);
		for (int i = 0; i < NumInputs; i++)
			case (pattern)
				0: stimVec[i] = 8'sh7f;
				1: stimVec[i] = 8'sh80;
				2: stimVec[i] = 8'sh01;
				default: stimVec[i] = i[0] ? 8'sh81 : 8'sh7f;
			endcase
	endfunction

	// Starts on a rising edge, returns on the edge after the last strobe
	task automatic strobeVector(input int testId, input int maxGaps);
		int gaps;
		gaps = 0;
		for (int i = 0; i < NumInputs; i++)
		begin
			if (gaps < maxGaps && $urandom_range(3, 0) == 0)
			begin
				actStrobe <= 1'b0;
				@(posedge clk);
				gaps++;
			end
			actIn <= stimVec[i];
			actStrobe <= 1'b1;
			@(posedge clk);
		end
		actStrobe <= 1'b0;
		pushExpected(testId);
		vectorsSent++;
	endtask

	task automatic waitDone();
		do
			@(posedge clk);
		while (!done);
	endtask

	// Retires one expected record per strobe
	always @(posedge clk)
	begin
		if (!reset && resultStrobe)
		begin
			if (expectQ.size() > 0)
			begin
				void'(expectQ.pop_front());
				void'(testQ.pop_front());
				refreshHead();
			end
			strobeCount <= done ? 0 : strobeCount + 1;
			if (done)
				vectorsDone <= vectorsDone + 1;
		end
	end

	assert property (@(posedge clk) disable iff (reset) resultStrobe |-> !expectEmpty)
	else
	begin
		protocolErrors++;
		$display("Result strobe for neuron %0d with no result expected", $sampled(result.index));
	end

	assert property (@(posedge clk) disable iff (reset)
		resultStrobe && !expectEmpty |-> result.value == expectHead.value)
	else
	begin
		valueErrors++;
		$display("CHECK FAILED %s neuron %0d value: expected %0d, actual %0d",
			testLabel($sampled(headTest)), $sampled(expectHead.index),
			$sampled(expectHead.value), $sampled(result.value));
	end

	assert property (@(posedge clk) disable iff (reset)
		resultStrobe && !expectEmpty |-> result.index == expectHead.index)
	else
	begin
		valueErrors++;
		$display("CHECK FAILED %s index: expected %0d, actual %0d",
			testLabel($sampled(headTest)), $sampled(expectHead.index),
			$sampled(result.index));
	end

	assert property (@(posedge clk) disable iff (reset)
		done |-> resultStrobe && strobeCount == NumNeurons - 1)
	else
	begin
		protocolErrors++;
		$display("Done pulsed after %0d earlier strobes instead of %0d",
			$sampled(strobeCount), NumNeurons - 1);
	end

	assert property (@(posedge clk) disable iff (reset)
		resultStrobe && result.index == LastIndex |-> done)
	else
	begin
		protocolErrors++;
		$display("Last neuron came out without a done pulse");
	end

	assert property (@(posedge clk) disable iff (reset) done |=> !busy)
	else
	begin
		protocolErrors++;
		$display("Busy stayed high after done");
	end

	assert property (@(posedge clk) disable iff (reset) resultStrobe |-> busy)
	else
	begin
		protocolErrors++;
		$display("Result strobe while busy was low");
	end

	// Covers reset and the filling phase of every vector
	assert property (@(posedge clk) disable iff (reset)
		!vectorPending |-> !busy && !resultStrobe && !done)
	else
	begin
		protocolErrors++;
		$display("Outputs active while no full vector had been strobed");
	end

	initial
	begin
		actIn = '0;
		actStrobe = 1'b0;
		void'($urandom(32'h26d5_86b0));
		refreshHead();
		@(posedge clk);
		while (reset)
			@(posedge clk);
		repeat (5) @(posedge clk);
		for (int p = 0; p < NumDirected; p++)
		begin
			patternVector(p);
			strobeVector(DirectedTest, 0);
			waitDone();
		end
		for (int v = 0; v < NumRandom; v++)
		begin
			repeat (2) @(posedge clk);
			randomVector();
			strobeVector(RandomTest, 0);
			waitDone();
		end
		for (int v = 0; v < NumGapped; v++)
		begin
			repeat ($urandom_range(2, 1)) @(posedge clk);
			randomVector();
			strobeVector(GappedTest, 3);
			waitDone();
		end
		for (int v = 0; v < NumBackToBack; v++)
		begin
			randomVector(); // First strobe goes out on the edge right after done
			strobeVector(BackToBackTest, 0);
			waitDone();
		end
		repeat (4) @(posedge clk);
		if (expectQ.size() != 0)
		begin
			protocolErrors++;
			$display("%0d expected results never came out", expectQ.size());
		end
		if (clampHits == 0 || wrapHits == 0)
		begin
			protocolErrors++;
			$display("Directed vectors gave %0d clamped and %0d wrapped positive neurons",
				clampHits, wrapHits);
		end
		$display("Errors: %0d value, %0d protocol", valueErrors, protocolErrors);
		if (valueErrors == 0 && protocolErrors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		repeat (TimeoutCycles) @(posedge clk);
		$display("Run hung, watchdog expired after %0d cycles", TimeoutCycles);
		$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
